//--- compile.f
hw/arbiter_pkg.sv
hw/request_matrix.sv
hw/x_roundrobin.sv
hw/y_roundrobin.sv
hw/grant_scheduler.sv
hw/grant_fifo.sv
hw/cell_arbiter_top.sv
tests/tb_cell_arbiter.sv

//--- hw/arbiter_pkg.sv
// Shared sizes, records and scheduler states for the 4x4 cell arbiter
// ROWS and COLS must be powers of two matching ROW_W and COL_W
// FIFO_DEPTH must be a power of two so the queue pointers wrap on their own
package arbiter_pkg;

    localparam int ROWS        = 4;        // Grid rows
    localparam int COLS        = 4;        // Grid columns
    localparam int ROW_W       = 2;        // Row index width
    localparam int COL_W       = 2;        // Column index width

    localparam int FIFO_DEPTH  = 4;        // Grant queue entries, also scheduler credits
    localparam int OUT_CREDITS = 2;        // Credits toward the outside consumer
    localparam int PTR_W       = 2;        // Queue pointer width
    localparam int CNT_W       = 3;        // Counter width, holds 0 to FIFO_DEPTH

    // Request event naming one cell
    typedef struct packed {
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
    } req_t;

    // Granted cell, also used for pending clears
    typedef struct packed {
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
    } grant_t;

    // Scheduler FSM states
    typedef enum logic [1:0] {
        SCHED_IDLE         = 2'd0,         // Nothing pending
        SCHED_ROW_SELECT   = 2'd1,         // One cycle, row arbiter advances
        SCHED_COLUMN_GRANT = 2'd2          // Column arbiter serves the held row
    } sched_state_t;

endpackage

//--- hw/cell_arbiter_top.sv
// 4x4 cell arbiter, request matrix feeding a scheduler and a credited grant queue
// One grant per cycle at most, latency varies with load and output credits
// The outside consumer must return one credit_i pulse per grant_valid_o
`timescale 1ns/1ps

module cell_arbiter_top
(
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                req_valid_i,     // One-cycle request event
    input  arbiter_pkg::req_t   req_i,
    input  logic                credit_i,        // One-cycle credit return
    output logic                grant_valid_o,   // One-cycle grant pulse
    output arbiter_pkg::grant_t grant_o
);

    logic [arbiter_pkg::ROWS-1:0][arbiter_pkg::COLS-1:0] pending;
    logic                clear_valid;
    arbiter_pkg::grant_t clear_cell;
    logic                push_valid;
    arbiter_pkg::grant_t push_grant;
    logic                fifo_credit;

    request_matrix u_matrix
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .clear_valid_i (clear_valid),
        .clear_cell_i  (clear_cell),
        .pending_o     (pending)
    );

    grant_scheduler u_sched
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .pending_i     (pending),
        .fifo_credit_i (fifo_credit),
        .clear_valid_o (clear_valid),
        .clear_cell_o  (clear_cell),
        .push_valid_o  (push_valid),
        .push_grant_o  (push_grant)
    );

    grant_fifo u_fifo
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .push_valid_i  (push_valid),
        .push_grant_i  (push_grant),
        .credit_i      (credit_i),
        .fifo_credit_o (fifo_credit),
        .grant_valid_o (grant_valid_o),
        .grant_o       (grant_o)
    );

endmodule

//--- hw/grant_fifo.sv
// Grant queue, circular buffer of FIFO_DEPTH entries
// Pops only while an output credit is held, returns a scheduler credit per pop
// grant_valid_o and grant_o are registered, one cycle behind the pop
`timescale 1ns/1ps

module grant_fifo
(
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                push_valid_i,
    input  arbiter_pkg::grant_t push_grant_i,
    input  logic                credit_i,        // Output credit back from consumer
    output logic                fifo_credit_o,   // Credit back to scheduler
    output logic                grant_valid_o,
    output arbiter_pkg::grant_t grant_o
);

    arbiter_pkg::grant_t mem [arbiter_pkg::FIFO_DEPTH];

    logic [arbiter_pkg::PTR_W-1:0] wr_ptr_q;
    logic [arbiter_pkg::PTR_W-1:0] rd_ptr_q;
    logic [arbiter_pkg::CNT_W-1:0] count_q;            // Entries held
    logic [arbiter_pkg::CNT_W-1:0] out_cred_q;         // Credits toward consumer
    logic [arbiter_pkg::CNT_W-1:0] push_cnt;
    logic [arbiter_pkg::CNT_W-1:0] pop_cnt;
    logic [arbiter_pkg::CNT_W-1:0] ret_cnt;
    logic                          pop;

    assign pop      = (count_q != '0) && (out_cred_q != '0);
    assign push_cnt = {{(arbiter_pkg::CNT_W-1){1'b0}}, push_valid_i};
    assign pop_cnt  = {{(arbiter_pkg::CNT_W-1){1'b0}}, pop};
    assign ret_cnt  = {{(arbiter_pkg::CNT_W-1){1'b0}}, credit_i};

    assign fifo_credit_o = pop;                          // Freed slot goes back at once

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            wr_ptr_q      <= '0;
            rd_ptr_q      <= '0;
            count_q       <= '0;
            out_cred_q    <= arbiter_pkg::CNT_W'(arbiter_pkg::OUT_CREDITS);
            grant_valid_o <= 1'b0;
        end
        else
        begin
            if (push_valid_i)
            begin
                wr_ptr_q <= wr_ptr_q + 1'b1;             // Wraps at FIFO_DEPTH
            end
            if (pop)
            begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q       <= count_q + push_cnt - pop_cnt;
            out_cred_q    <= out_cred_q - pop_cnt + ret_cnt;
            grant_valid_o <= pop;                        // One pulse per delivered grant
        end
    end

    // Storage and output payload
    always_ff @(posedge clk_i)
    begin
        if (push_valid_i)
        begin
            mem[wr_ptr_q] <= push_grant_i;
        end
        if (pop)
        begin
            grant_o <= mem[rd_ptr_q];
        end
    end

    // Scheduler credits should make this impossible
    a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
        push_valid_i |-> (count_q != arbiter_pkg::CNT_W'(arbiter_pkg::FIFO_DEPTH)))
        else $error("Push into a full grant queue");

endmodule

//--- hw/grant_scheduler.sv
// Producer side, walks rows then columns and pushes one grant per cycle at most
// Holds FIFO_DEPTH credits toward the grant queue, one spent per push
// A registered column grant clears and pushes on the next edge
`timescale 1ns/1ps

module grant_scheduler
(
    input  logic                                             clk_i,
    input  logic                                             reset_i,
    input  logic [arbiter_pkg::ROWS-1:0][arbiter_pkg::COLS-1:0] pending_i,
    input  logic                                             fifo_credit_i, // Queue popped
    output logic                                             clear_valid_o,
    output arbiter_pkg::grant_t                              clear_cell_o,
    output logic                                             push_valid_o,
    output arbiter_pkg::grant_t                              push_grant_o
);

    arbiter_pkg::sched_state_t state_q, state_d;

    logic [arbiter_pkg::CNT_W-1:0] credit_q;
    logic [arbiter_pkg::CNT_W-1:0] push_cnt;            // Credit spent this cycle
    logic [arbiter_pkg::CNT_W-1:0] ret_cnt;             // Credit returned this cycle
    logic [arbiter_pkg::ROWS-1:0]  row_req;             // Rows with any pending cell
    logic [arbiter_pkg::ROWS-1:0]  row_onehot;
    logic [arbiter_pkg::ROW_W-1:0] row_sel;
    logic [arbiter_pkg::COLS-1:0]  col_gnt;
    logic [arbiter_pkg::COL_W-1:0] col_idx;
    logic [arbiter_pkg::COLS-1:0]  row_left;            // Held row minus grant in flight
    logic                          others_pending;
    logic                          row_advance;
    logic                          col_enable;

    always_comb
    begin
        for (int r = 0; r < arbiter_pkg::ROWS; r++)
        begin
            row_req[r] = |pending_i[r];
        end
    end

    assign row_onehot     = {{(arbiter_pkg::ROWS-1){1'b0}}, 1'b1} << row_sel;
    assign row_left       = pending_i[row_sel] & ~col_gnt;
    assign others_pending = |(row_req & ~row_onehot);

    assign push_cnt = {{(arbiter_pkg::CNT_W-1){1'b0}}, push_valid_o};
    assign ret_cnt  = {{(arbiter_pkg::CNT_W-1){1'b0}}, fifo_credit_i};

    assign row_advance = (state_q == arbiter_pkg::SCHED_ROW_SELECT);
    // Keep a credit back for the grant already in flight
    assign col_enable  = (state_q == arbiter_pkg::SCHED_COLUMN_GRANT) && (credit_q > push_cnt);

    x_roundrobin u_x_rr
    (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .advance_i (row_advance),
        .row_req_i (row_req),
        .row_o     (row_sel)                            // Held row
    );

    y_roundrobin u_y_rr
    (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .enable_i (col_enable),
        .req_i    (pending_i[row_sel]),
        .gnt_o    (col_gnt),
        .yadd_o   (col_idx)
    );

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            arbiter_pkg::SCHED_IDLE:
            begin
                if (|row_req)
                begin
                    state_d = arbiter_pkg::SCHED_ROW_SELECT;
                end
            end
            arbiter_pkg::SCHED_ROW_SELECT:
            begin
                state_d = arbiter_pkg::SCHED_COLUMN_GRANT; // Row registered this edge
            end
            arbiter_pkg::SCHED_COLUMN_GRANT:
            begin
                if (!(|row_left))
                begin
                    state_d = others_pending ? arbiter_pkg::SCHED_ROW_SELECT
                                             : arbiter_pkg::SCHED_IDLE;
                end
            end
            default:
            begin
                state_d = arbiter_pkg::SCHED_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q  <= arbiter_pkg::SCHED_IDLE;
            credit_q <= arbiter_pkg::CNT_W'(arbiter_pkg::FIFO_DEPTH);
        end
        else
        begin
            state_q  <= state_d;
            credit_q <= credit_q - push_cnt + ret_cnt;
        end
    end

    // Grant record straight from the registered column grant
    assign push_valid_o     = |col_gnt;
    assign push_grant_o.row = row_sel;
    assign push_grant_o.col = col_idx;
    assign clear_valid_o    = push_valid_o;
    assign clear_cell_o     = push_grant_o;

    a_push_credit: assert property (@(posedge clk_i) disable iff (reset_i)
        push_valid_o |-> (credit_q != '0))
        else $error("Push without a queue credit");

endmodule

//--- hw/request_matrix.sv
// Pending flag per grid cell
// Duplicate requests merge into the existing flag
// A clear beats a set to the same cell in the same cycle
`timescale 1ns/1ps

module request_matrix
(
    input  logic                                             clk_i,
    input  logic                                             reset_i,
    input  logic                                             req_valid_i,   // Request event
    input  arbiter_pkg::req_t                                req_i,
    input  logic                                             clear_valid_i, // Grant clear
    input  arbiter_pkg::grant_t                              clear_cell_i,
    output logic [arbiter_pkg::ROWS-1:0][arbiter_pkg::COLS-1:0] pending_o
);

    logic [arbiter_pkg::ROWS-1:0][arbiter_pkg::COLS-1:0] pending_q;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            pending_q <= '0;
        end
        else
        begin
            if (req_valid_i)
            begin
                pending_q[req_i.row][req_i.col] <= 1'b1;
            end
            // Later assignment so the clear takes priority
            if (clear_valid_i)
            begin
                pending_q[clear_cell_i.row][clear_cell_i.col] <= 1'b0;
            end
        end
    end

    assign pending_o = pending_q;

    // Scheduler must only clear cells it saw pending
    a_clear_pending: assert property (@(posedge clk_i) disable iff (reset_i)
        clear_valid_i |-> pending_q[clear_cell_i.row][clear_cell_i.col])
        else $error("Clear of a cell that is not pending");

endmodule

//--- hw/x_roundrobin.sv
// Row arbiter, round-robin over rows that hold pending cells
// The chosen row only moves on advance_i and is held otherwise
// Resets to the last row so the first pick is row 0
`timescale 1ns/1ps

module x_roundrobin
(
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          advance_i,  // Register the next row
    input  logic [arbiter_pkg::ROWS-1:0]  row_req_i,  // One bit per non-empty row
    output logic [arbiter_pkg::ROW_W-1:0] row_o       // Current row
);

    logic [arbiter_pkg::ROW_W-1:0] row_q;
    logic [arbiter_pkg::ROW_W-1:0] row_next;
    logic [arbiter_pkg::ROWS-1:0]  above;               // Requests past the last row
    logic [arbiter_pkg::ROWS-1:0]  cand;                // Set the pick is taken from

    always_comb
    begin
        above = row_req_i;
        for (int r = 0; r < arbiter_pkg::ROWS; r++)
        begin
            if (r <= int'(row_q))
            begin
                above[r] = 1'b0;                        // Drop rows up to the last one
            end
        end
        cand     = (|above) ? above : row_req_i;      // Wrap to lowest pending row
        row_next = row_q;
        for (int r = arbiter_pkg::ROWS - 1; r >= 0; r--)
        begin
            if (cand[r])
            begin
                row_next = r[arbiter_pkg::ROW_W-1:0];   // Lowest set bit wins
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            row_q <= {arbiter_pkg::ROW_W{1'b1}};        // Last row, next pick wraps to 0
        end
        else if (advance_i && (|row_req_i))
        begin
            row_q <= row_next;
        end
    end

    assign row_o = row_q;

endmodule

//--- hw/y_roundrobin.sv
// Column arbiter for the selected row with a registered one-hot grant
// Masked round-robin with fallback to the lowest unmasked request
// The grant in flight is excluded since its pending bit clears one edge later
`timescale 1ns/1ps

module y_roundrobin
(
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          enable_i,   // Low resets mask and grant
    input  logic [arbiter_pkg::COLS-1:0]  req_i,      // Pending bits of the held row
    output logic [arbiter_pkg::COLS-1:0]  gnt_o,      // Registered one-hot grant
    output logic [arbiter_pkg::COL_W-1:0] yadd_o      // Index of gnt_o
);

    logic [arbiter_pkg::COLS-1:0] mask_q;
    logic [arbiter_pkg::COLS-1:0] mask_next;
    logic [arbiter_pkg::COLS-1:0] live_req;           // Requests minus grant in flight
    logic [arbiter_pkg::COLS-1:0] mask_req;
    logic [arbiter_pkg::COLS-1:0] pick_req;
    logic [arbiter_pkg::COLS-1:0] gnt_next;

    assign live_req = req_i & ~gnt_o;
    assign mask_req = live_req & mask_q;
    assign pick_req = (|mask_req) ? mask_req : live_req; // Fallback avoids starving low columns
    assign gnt_next = pick_req & (~pick_req + 1'b1);      // Isolate lowest set bit

    // Mask clears every column up to and including the new grant
    always_comb
    begin
        mask_next = mask_q;                             // No grant keeps the mask
        for (int i = 0; i < arbiter_pkg::COLS; i++)
        begin
            if (gnt_next[i])
            begin
                mask_next = {arbiter_pkg::COLS{1'b1}} << (i + 1);
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            mask_q <= {arbiter_pkg::COLS{1'b1}};
            gnt_o  <= '0;
        end
        else if (enable_i)
        begin
            mask_q <= mask_next;
            gnt_o  <= gnt_next;
        end
        else
        begin
            mask_q <= {arbiter_pkg::COLS{1'b1}};        // Fresh sweep for the next row
            gnt_o  <= '0;
        end
    end

    // Encode the registered grant
    always_comb
    begin
        yadd_o = '0;
        for (int i = 0; i < arbiter_pkg::COLS; i++)
        begin
            if (gnt_o[i])
            begin
                yadd_o = i[arbiter_pkg::COL_W-1:0];
            end
        end
    end

    // Granted column stays pending until the clear one edge later
    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0))
        else $error("Column grant is not one-hot or not pending");

endmodule

//--- run.sh
#!/bin/sh
# Build and run the cell arbiter testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cell_arbiter -Mdir obj_dir -o sim_cell_arbiter -f compile.f

output=$(./obj_dir/sim_cell_arbiter || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "Finished with no errors"; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

//--- tests/arbiter_stimulus.txt
# Columns: op a b
# R row col request, W n wait cycles, P 1 or 0 consumer pause on or off, G row col expected grant
# Full grid requested row-major, served row by row with columns ascending
R 0 0
R 0 1
R 0 2
R 0 3
R 1 0
R 1 1
R 1 2
R 1 3
R 2 0
R 2 1
R 2 2
R 2 3
R 3 0
R 3 1
R 3 2
R 3 3
G 0 0
G 0 1
G 0 2
G 0 3
G 1 0
G 1 1
G 1 2
G 1 3
G 2 0
G 2 1
G 2 2
G 2 3
G 3 0
G 3 1
G 3 2
G 3 3
W 12
# Duplicate requests merge, one grant each, row 2 before the wrap to row 0
R 2 1
R 2 1
R 0 2
R 0 2
G 2 1
G 0 2
W 12
# Consumer paused, rows 1 and 3, only two grants get out and the scheduler stalls in row 3
P 1
R 1 0
R 1 1
R 1 2
R 1 3
R 3 0
R 3 1
R 3 3
G 1 0
G 1 1
W 10
# Late requests while stalled, row 3 takes its new cell before row 1 comes back
R 3 2
R 1 1
W 3
P 0
G 1 2
G 1 3
G 3 0
G 3 1
G 3 2
G 3 3
G 1 1
# Everything served, grant_valid_o stays low
W 20

//--- tests/tb_cell_arbiter.sv
// Run from the project root, reads tests/arbiter_stimulus.txt
// Grant order comes from the file, a pending-cell model catches lost or doubled grants
// Inputs change on the falling edge, outputs are sampled on the rising edge
`timescale 1ns/1ps

module tb_cell_arbiter;

    localparam int TIMEOUT_CYCLES = 200;                   // Limit for each wait loop

    logic                clk_i;
    logic                reset_i;
    logic                req_valid_i;
    arbiter_pkg::req_t   req_i;
    logic                credit_i;
    logic                grant_valid_o;
    arbiter_pkg::grant_t grant_o;

    logic [arbiter_pkg::ROWS-1:0][arbiter_pkg::COLS-1:0] model_pending; // Reference pending set
    arbiter_pkg::grant_t seen_q [$];                        // Delivered, not yet checked
    int                  grant_count;
    int                  expect_count;
    int                  owed;                              // Credits the consumer holds
    int                  paused_grants;
    logic                paused;
    logic [31:0]         rng_state;
    logic [1:0]          hold;                              // Cycles left before next credit

    cell_arbiter_top DUT
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .credit_i      (credit_i),
        .grant_valid_o (grant_valid_o),
        .grant_o       (grant_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever
        begin
            #50 clk_i = ~clk_i;                             // 100 ns period
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "Stopped at the first failed check");
    endtask

    task automatic check_grant(input arbiter_pkg::grant_t exp, input arbiter_pkg::grant_t got);
        if (got !== exp)
        begin
            abort_run($sformatf("Mismatch grant_o: expected 0x%h got 0x%h", exp, got));
        end
    endtask

    task automatic check_count(input int exp, input int got);
        if (got != exp)
        begin
            abort_run($sformatf("Mismatch grant_valid_o pulse count: expected 0x%0h got 0x%0h",
                                exp, got));
        end
    endtask

    // Model side of a delivered grant, the cell must still be pending
    task automatic record_grant(input arbiter_pkg::grant_t got);
        if (!model_pending[got.row][got.col])
        begin
            abort_run($sformatf("Grant for row %0d column %0d which was not pending",
                                got.row, got.col));
        end
        model_pending[got.row][got.col] = 1'b0;
        seen_q.push_back(got);
        grant_count++;
        owed++;                                             // Consumer now owes a credit
        if (paused)
        begin
            paused_grants++;
            if (paused_grants > arbiter_pkg::OUT_CREDITS)
            begin
                abort_run("More grants than output credits while the consumer was paused");
            end
        end
    endtask

    task automatic send_request(input int row, input int col);
        req_valid_i = 1'b1;
        req_i.row   = row[arbiter_pkg::ROW_W-1:0];
        req_i.col   = col[arbiter_pkg::COL_W-1:0];
        @(negedge clk_i);
        req_valid_i = 1'b0;                                 // One-cycle event
    endtask

    task automatic expect_grant(input int row, input int col);
        arbiter_pkg::grant_t exp;
        arbiter_pkg::grant_t got;
        int                  waited;
        exp.row = row[arbiter_pkg::ROW_W-1:0];
        exp.col = col[arbiter_pkg::COL_W-1:0];
        waited  = 0;
        expect_count++;
        while (seen_q.size() == 0)
        begin
            if (waited >= TIMEOUT_CYCLES)
            begin
                abort_run("Timed out waiting for a grant on grant_valid_o");
            end
            @(negedge clk_i);
            waited++;
        end
        got = seen_q.pop_front();
        check_grant(exp, got);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_i);
    endtask

    task automatic set_pause(input int on);
        paused = (on != 0);                                 // Consumer keeps its credits
    endtask

    // Monitor and consumer share one process so model updates stay ordered
    initial
    begin : monitor_consumer
        logic give;
        credit_i      = 1'b0;
        owed          = 0;
        hold          = 2'd0;
        rng_state     = 32'd36659;
        model_pending = '0;
        grant_count   = 0;
        paused_grants = 0;
        forever
        begin
            @(posedge clk_i);
            give = 1'b0;
            if (!reset_i)
            begin
                if (grant_valid_o)
                begin
                    record_grant(grant_o);                  // Clear before a new set
                end
                if (req_valid_i)
                begin
                    model_pending[req_i.row][req_i.col] = 1'b1; // Duplicates merge
                end
                if (!paused)
                begin
                    paused_grants = 0;
                end
                if (!paused && owed > 0)
                begin
                    if (hold == 2'd0)
                    begin
                        give      = 1'b1;
                        owed--;
                        rng_state = xorshift32(rng_state);
                        hold      = rng_state[1:0];         // Delay 0 to 3 cycles
                    end
                    else
                    begin
                        hold = hold - 2'd1;
                    end
                end
            end
            @(negedge clk_i);
            credit_i = give;
        end
    end

    initial
    begin : stimulus
        int         fd;
        int         n;
        int         a;
        int         b;
        logic [7:0] op;
        string      line;
        reset_i      = 1'b1;
        req_valid_i  = 1'b0;
        req_i        = '0;
        paused       = 1'b0;
        expect_count = 0;
        repeat (3) @(negedge clk_i);
        reset_i = 1'b0;
        fd = $fopen("tests/arbiter_stimulus.txt", "r");
        if (fd == 0)
        begin
            abort_run("Could not open tests/arbiter_stimulus.txt");
        end
        while ($fgets(line, fd) != 0)
        begin
            n = $sscanf(line, "%c %d %d", op, a, b);
            if (n < 2)
            begin
                continue;                                   // Comment or blank line
            end
            case (op)
                "R": send_request(a, b);
                "G": expect_grant(a, b);
                "W": wait_cycles(a);
                "P": set_pause(a);
                default: abort_run($sformatf("Unknown line in the stimulus file: %s", line));
            endcase
        end
        $fclose(fd);
        // Extra pulses during the last waits show up as a count difference
        check_count(expect_count, grant_count);
        if (model_pending != '0)
        begin
            abort_run("Cells still pending in the reference model at the end of the run");
        end
        else
        begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule
